// File: project.f
rob_pkg.sv
tag_cam.sv
rob.sv
rob_top.sv
rob_tb.sv

// File: rob.sv
`timescale 1ns/1ps

module rob #(
	parameter int SS_WIDTH  = rob_pkg::SS_WIDTH_DEF,
	parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
	parameter int PREG_BITS = rob_pkg::PREG_BITS_DEF
) (
	input  logic                                         clock,
	input  logic                                         rst_n,
	input  logic                                         flush,

	// Dispatch, slot 0 oldest
	input  logic [SS_WIDTH-1:0]                          disp_valid,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           t_new,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           t_old,
	input  logic [SS_WIDTH-1:0][rob_pkg::ARCH_BITS-1:0]  arch_dest,
	input  rob_pkg::op_class_e [SS_WIDTH-1:0]            op,
	input  logic [SS_WIDTH-1:0][31:0]                    npc,
	output logic [SS_WIDTH-1:0]                          disp_ready,
	output logic [SS_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0]   disp_idx,

	// Completion broadcasts
	input  logic [SS_WIDTH-1:0]                          cdb_valid,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           cdb_tag,

	// Branch resolution, one per cycle
	input  logic                                         br_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0]                 br_idx,
	input  logic                                         br_taken,
	input  logic [31:0]                                  br_target,

	// Retire, slot 0 oldest
	input  logic                                         ret_ready,
	output logic [SS_WIDTH-1:0]                          ret_valid,
	output logic [SS_WIDTH-1:0][PREG_BITS-1:0]           ret_t_new,
	output logic [SS_WIDTH-1:0][PREG_BITS-1:0]           ret_t_old,
	output logic [SS_WIDTH-1:0][rob_pkg::ARCH_BITS-1:0]  ret_arch_dest,
	output rob_pkg::op_class_e [SS_WIDTH-1:0]            ret_op,
	output logic [SS_WIDTH-1:0]                          ret_taken,
	output logic [SS_WIDTH-1:0][31:0]                    ret_target,

	output logic [$clog2(ROB_DEPTH+1)-1:0]               free_count
);
	import rob_pkg::*;

	localparam int IDX_BITS = $clog2(ROB_DEPTH);
	localparam int CNT_BITS = $clog2(ROB_DEPTH + 1);

	rob_entry_t [ROB_DEPTH-1:0] rows_q, rows_d;

	logic [IDX_BITS-1:0] head_q, head_d; // Oldest row
	logic [IDX_BITS-1:0] tail_q, tail_d; // Next free row
	logic [CNT_BITS-1:0] count_q, count_d; // Occupied rows

	logic [ROB_DEPTH-1:0][PREG_BITS-1:0] entry_tag;
	logic [ROB_DEPTH-1:0]                cam_hit;
	logic [SS_WIDTH-1:0]                 disp_hit;
	logic [ROB_DEPTH-1:0]                done;

	logic [SS_WIDTH-1:0][IDX_BITS-1:0] ret_idx;
	logic [CNT_BITS-1:0]               ret_cnt;
	logic [CNT_BITS-1:0]               free_ret; // Free rows once retirement is applied
	logic [CNT_BITS-1:0]               disp_cnt;
	logic [SS_WIDTH-1:0]               disp_fire;

	always_comb begin
		for (int e = 0; e < ROB_DEPTH; e++) begin
			entry_tag[e] = rows_q[e].t_new;
		end
	end

	// Wakeup of stored rows
	tag_cam #(
		.DEPTH    (ROB_DEPTH),
		.LANES    (SS_WIDTH),
		.TAG_BITS (PREG_BITS)
	) cam_i (
		.lane_valid (cdb_valid),
		.lane_tag   (cdb_tag),
		.entry_tag  (entry_tag),
		.hit        (cam_hit)
	);

	// Incoming tags can complete in the same cycle they dispatch
	tag_cam #(
		.DEPTH    (SS_WIDTH),
		.LANES    (SS_WIDTH),
		.TAG_BITS (PREG_BITS)
	) disp_cam_i (
		.lane_valid (cdb_valid),
		.lane_tag   (cdb_tag),
		.entry_tag  (t_new),
		.hit        (disp_hit)
	);

	always_comb begin
		for (int e = 0; e < ROB_DEPTH; e++) begin
			done[e] = rows_q[e].busy && (rows_q[e].ready || cam_hit[e]);
		end
	end

	// Retire scan, stops at the first row not done
	always_comb begin
		logic run;
		run = ~flush;
		ret_cnt = '0;
		for (int j = 0; j < SS_WIDTH; j++) begin
			ret_idx[j] = head_q + IDX_BITS'(j);
			run = run && done[ret_idx[j]];
			ret_valid[j] = run;
			if (run && ret_ready)
				ret_cnt = ret_cnt + 1'b1;
		end
	end

	// Retire payload straight from the table
	always_comb begin
		for (int j = 0; j < SS_WIDTH; j++) begin
			ret_t_new[j]     = rows_q[ret_idx[j]].t_new;
			ret_t_old[j]     = rows_q[ret_idx[j]].t_old;
			ret_arch_dest[j] = rows_q[ret_idx[j]].arch_dest;
			ret_op[j]        = rows_q[ret_idx[j]].op;
			if (br_valid && br_idx == ret_idx[j]) begin
				// Resolution landing on a retiring row
				ret_taken[j]  = br_taken;
				ret_target[j] = br_target;
			end else begin
				ret_taken[j]  = rows_q[ret_idx[j]].taken;
				ret_target[j] = rows_q[ret_idx[j]].target;
			end
		end
	end

	assign free_ret = CNT_BITS'(ROB_DEPTH) - count_q + ret_cnt;

	// Slot i needs i+1 free rows
	always_comb begin
		disp_cnt = '0;
		for (int i = 0; i < SS_WIDTH; i++) begin
			disp_ready[i] = ~flush && (free_ret > CNT_BITS'(i));
			disp_idx[i]   = tail_q + IDX_BITS'(i);
			disp_fire[i]  = disp_valid[i] && disp_ready[i];
			if (disp_fire[i])
				disp_cnt = disp_cnt + 1'b1;
		end
	end

	assign free_count = flush ? CNT_BITS'(ROB_DEPTH) : free_ret - disp_cnt;

	// Next-state table
	always_comb begin
		rows_d = rows_q;

		for (int e = 0; e < ROB_DEPTH; e++) begin
			if (rows_q[e].busy && cam_hit[e])
				rows_d[e].ready = 1'b1;
		end

		if (br_valid) begin
			rows_d[br_idx].taken  = br_taken;
			rows_d[br_idx].target = br_target;
		end

		for (int j = 0; j < SS_WIDTH; j++) begin
			if (ret_valid[j] && ret_ready)
				rows_d[ret_idx[j]].busy = 1'b0;
		end

		// Dispatch last, may reuse a row freed above
		for (int i = 0; i < SS_WIDTH; i++) begin
			if (disp_fire[i]) begin
				rows_d[disp_idx[i]].busy      = 1'b1;
				rows_d[disp_idx[i]].ready     = disp_hit[i];
				rows_d[disp_idx[i]].t_new     = t_new[i];
				rows_d[disp_idx[i]].t_old     = t_old[i];
				rows_d[disp_idx[i]].arch_dest = arch_dest[i];
				rows_d[disp_idx[i]].op        = op[i];
				rows_d[disp_idx[i]].npc       = npc[i];
				rows_d[disp_idx[i]].taken     = 1'b0;
				rows_d[disp_idx[i]].target    = npc[i]; // Fall-through until resolved
			end
		end

		head_d  = head_q + IDX_BITS'(ret_cnt);
		tail_d  = tail_q + IDX_BITS'(disp_cnt);
		count_d = count_q - ret_cnt + disp_cnt;

		if (flush) begin
			for (int e = 0; e < ROB_DEPTH; e++) begin
				rows_d[e].busy  = 1'b0;
				rows_d[e].ready = 1'b0;
			end
			head_d  = head_q;
			tail_d  = head_q; // Empty, restart at head
			count_d = '0;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			for (int e = 0; e < ROB_DEPTH; e++) begin
				rows_q[e].busy  <= 1'b0;
				rows_q[e].ready <= 1'b0;
			end
		end else begin
			head_q  <= head_d;
			tail_q  <= tail_d;
			count_q <= count_d;
			rows_q  <= rows_d;
		end
	end

endmodule

// File: rob_golden.txt
# C dv tn0 to0 ad0 op0 npc0 tn1 to1 ad1 op1 npc1 cv tag0 tag1 bv bser bt btgt flush rr
# R t_new t_old arch_dest op taken target   (expected retire order, rr 2 = random)
C 3 01 21 00 0 100 02 22 01 1 104 0 00 00 0 0 0 0 0 1
C 3 03 23 02 0 108 04 24 03 2 10c 1 04 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 3 03 02 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 2 00 01 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 0 00 00 0 0 0 0 0 1
C 3 05 25 04 3 110 06 26 05 0 114 0 00 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 1 06 00 1 4 1 200 0 1
C 0 00 00 00 0 0 00 00 00 0 0 2 00 05 0 0 0 0 0 1
C 1 07 27 06 3 118 00 00 00 0 0 0 00 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 1 07 00 1 6 1 300 0 1
C 3 08 28 07 0 11c 09 29 08 0 120 1 08 00 0 0 0 0 0 0
C 3 0a 2a 09 1 124 0b 2b 0a 0 128 1 0a 00 0 0 0 0 0 0
C 3 0c 2c 0b 0 12c 0d 2d 0c 2 130 0 00 00 0 0 0 0 0 0
C 3 0e 2e 0d 0 134 0f 2f 0e 0 138 0 00 00 0 0 0 0 0 0
C 0 00 00 00 0 0 00 00 00 0 0 0 00 00 0 0 0 0 0 0
C 3 10 30 0f 0 13c 11 31 10 4 140 1 09 00 0 0 0 0 0 2
C 0 00 00 00 0 0 00 00 00 0 0 3 0b 0c 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 3 0d 0e 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 3 10 0f 0 0 0 0 0 2
C 0 00 00 00 0 0 00 00 00 0 0 1 11 00 0 0 0 0 0 2
C 0 00 00 00 0 0 00 00 00 0 0 0 00 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 0 00 00 0 0 0 0 0 1
C 3 12 32 11 0 144 13 33 12 0 148 0 00 00 0 0 0 0 0 1
C 3 14 34 13 1 14c 15 35 14 0 150 1 14 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 0 00 00 0 0 0 0 1 1
C 3 16 36 15 0 154 17 37 16 1 158 0 00 00 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 3 16 17 0 0 0 0 0 1
C 0 00 00 00 0 0 00 00 00 0 0 2 00 14 0 0 0 0 0 1
R 01 21 00 0 0 100
R 02 22 01 1 0 104
R 03 23 02 0 0 108
R 04 24 03 2 0 10c
R 05 25 04 3 1 200
R 06 26 05 0 0 114
R 07 27 06 3 1 300
R 08 28 07 0 0 11c
R 09 29 08 0 0 120
R 0a 2a 09 1 0 124
R 0b 2b 0a 0 0 128
R 0c 2c 0b 0 0 12c
R 0d 2d 0c 2 0 130
R 0e 2e 0d 0 0 134
R 0f 2f 0e 0 0 138
R 10 30 0f 0 0 13c
R 11 31 10 4 0 140
R 16 36 15 0 0 154
R 17 37 16 1 0 158

// File: rob_pkg.sv
package rob_pkg;

	// Defaults picked up by rob_top and passed down
	localparam int SS_WIDTH_DEF  = 2;
	localparam int ROB_DEPTH_DEF = 8; // Power of two, pointers wrap
	localparam int PREG_BITS_DEF = 6;

	// Architectural register index width
	localparam int ARCH_BITS = 5;

	// Operation class carried through to commit
	typedef enum logic [2:0] {
		OP_ALU    = 3'd0,
		OP_LOAD   = 3'd1,
		OP_STORE  = 3'd2,
		OP_BRANCH = 3'd3,
		OP_HALT   = 3'd4
	} op_class_e;

	// One row of the reorder buffer
	typedef struct packed {
		logic                     busy;      // Row holds a live instruction
		logic                     ready;     // Result broadcast seen
		logic [PREG_BITS_DEF-1:0] t_new;     // Destination tag from free list
		logic [PREG_BITS_DEF-1:0] t_old;     // Previous mapping, freed at retire
		logic [ARCH_BITS-1:0]     arch_dest;
		op_class_e                op;
		logic [31:0]              npc;
		logic                     taken;     // Written by branch resolution
		logic [31:0]              target;
	} rob_entry_t;

endpackage

// File: rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
	import rob_pkg::*;

	localparam int SS_WIDTH  = 2;
	localparam int ROB_DEPTH = 8;
	localparam int PREG_BITS = 6;
	localparam int IDX_BITS  = $clog2(ROB_DEPTH);
	localparam int CNT_BITS  = $clog2(ROB_DEPTH + 1);
	localparam int MAX_REC   = 64;
	localparam int NCOL      = 20;

	// Column positions of a C record
	localparam int F_DV   = 0;  // Slot fields follow, 5 per slot
	localparam int F_CV   = 11;
	localparam int F_TAG0 = 12;
	localparam int F_TAG1 = 13;
	localparam int F_BV   = 14;
	localparam int F_BSER = 15; // Dispatch serial number of the branch
	localparam int F_BT   = 16;
	localparam int F_BTGT = 17;
	localparam int F_FL   = 18;
	localparam int F_RR   = 19; // 0 low, 1 high, 2 random

	typedef struct packed {
		logic [PREG_BITS-1:0] t_new;
		logic [PREG_BITS-1:0] t_old;
		logic [ARCH_BITS-1:0] arch_dest;
		logic [2:0]           op;
		logic                 taken;
		logic [31:0]          target;
	} exp_ret_t;

	logic                                  clock;
	logic                                  rst_n;
	logic                                  flush;
	logic [SS_WIDTH-1:0]                   disp_valid;
	logic [SS_WIDTH-1:0][PREG_BITS-1:0]    t_new;
	logic [SS_WIDTH-1:0][PREG_BITS-1:0]    t_old;
	logic [SS_WIDTH-1:0][ARCH_BITS-1:0]    arch_dest;
	op_class_e [SS_WIDTH-1:0]              op;
	logic [SS_WIDTH-1:0][31:0]             npc;
	logic [SS_WIDTH-1:0]                   disp_ready;
	logic [SS_WIDTH-1:0][IDX_BITS-1:0]     disp_idx;
	logic [SS_WIDTH-1:0]                   cdb_valid;
	logic [SS_WIDTH-1:0][PREG_BITS-1:0]    cdb_tag;
	logic                                  br_valid;
	logic [IDX_BITS-1:0]                   br_idx;
	logic                                  br_taken;
	logic [31:0]                           br_target;
	logic                                  ret_ready;
	logic [SS_WIDTH-1:0]                   ret_valid;
	logic [SS_WIDTH-1:0][PREG_BITS-1:0]    ret_t_new;
	logic [SS_WIDTH-1:0][PREG_BITS-1:0]    ret_t_old;
	logic [SS_WIDTH-1:0][ARCH_BITS-1:0]    ret_arch_dest;
	op_class_e [SS_WIDTH-1:0]              ret_op;
	logic [SS_WIDTH-1:0]                   ret_taken;
	logic [SS_WIDTH-1:0][31:0]             ret_target;
	logic [CNT_BITS-1:0]                   free_count;

	int          stim [MAX_REC][NCOL];
	int          nrec;
	exp_ret_t    exp_q[$];
	int          idx_of [MAX_REC]; // Row index handed out per dispatch serial
	int          serial;
	int          occ, head, tail;  // Reference occupancy and pointers
	int          row_tag [ROB_DEPTH];
	bit          row_done [ROB_DEPTH]; // Reference completion per row
	logic [1:0]  cur_valid;        // Slots of the current bundle not yet accepted
	int          cur_f [2][5];
	logic [1:0]  fired;
	int          rec, cycles, limit;
	logic [31:0] rng;
	int          checks, value_errs, other_errs;
	bit          timed_out;

	rob_top #(
		.SS_WIDTH  (SS_WIDTH),
		.ROB_DEPTH (ROB_DEPTH),
		.PREG_BITS (PREG_BITS)
	) dut_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.disp_valid    (disp_valid),
		.t_new         (t_new),
		.t_old         (t_old),
		.arch_dest     (arch_dest),
		.op            (op),
		.npc           (npc),
		.disp_ready    (disp_ready),
		.disp_idx      (disp_idx),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.br_valid      (br_valid),
		.br_idx        (br_idx),
		.br_taken      (br_taken),
		.br_target     (br_target),
		.ret_ready     (ret_ready),
		.ret_valid     (ret_valid),
		.ret_t_new     (ret_t_new),
		.ret_t_old     (ret_t_old),
		.ret_arch_dest (ret_arch_dest),
		.ret_op        (ret_op),
		.ret_taken     (ret_taken),
		.ret_target    (ret_target),
		.free_count    (free_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// True when a valid CDB lane carries this tag in the current cycle
	function automatic bit tag_on_cdb(input int tag);
		for (int k = 0; k < SS_WIDTH; k++)
			if (cdb_valid[k] && cdb_tag[k] == PREG_BITS'(tag))
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			value_errs++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("Error: %s at %0t", msg, $time);
		other_errs++;
	endtask

	task automatic load_golden();
		int       fd;
		int       n;
		int       code;
		string    line;
		int       f [NCOL];
		int       r [6];
		exp_ret_t e;
		fd = $fopen("rob_golden.txt", "r");
		if (fd == 0) begin
			report_problem("could not open rob_golden.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() == 0)
				continue;
			if (line.getc(0) == "C" && nrec < MAX_REC) begin
				n = $sscanf(line,
					"C %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
				assert (n == NCOL) else report_problem("malformed stimulus line");
				for (int k = 0; k < NCOL; k++)
					stim[nrec][k] = f[k];
				nrec++;
			end else if (line.getc(0) == "R") begin
				n = $sscanf(line, "R %h %h %h %h %h %h", r[0], r[1], r[2], r[3], r[4], r[5]);
				assert (n == 6) else report_problem("malformed retire line");
				e.t_new     = PREG_BITS'(r[0]);
				e.t_old     = PREG_BITS'(r[1]);
				e.arch_dest = ARCH_BITS'(r[2]);
				e.op        = 3'(r[3]);
				e.taken     = r[4] != 0;
				e.target    = r[5];
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	task automatic load_bundle(input int r);
		if (r >= nrec) begin
			cur_valid = 2'b00;
			return;
		end
		cur_valid = 2'(stim[r][F_DV]);
		for (int s = 0; s < 2; s++)
			for (int c = 0; c < 5; c++)
				cur_f[s][c] = stim[r][1 + 5 * s + c];
	endtask

	task automatic drive_inputs();
		int mode;
		disp_valid = cur_valid;
		for (int s = 0; s < SS_WIDTH; s++) begin
			t_new[s]     = PREG_BITS'(cur_f[s][0]);
			t_old[s]     = PREG_BITS'(cur_f[s][1]);
			arch_dest[s] = ARCH_BITS'(cur_f[s][2]);
			op[s]        = op_class_e'(3'(cur_f[s][3]));
			npc[s]       = cur_f[s][4];
		end
		br_valid  = 1'b0;
		br_idx    = '0;
		br_taken  = 1'b0;
		br_target = '0;
		if (rec < nrec) begin
			cdb_valid  = 2'(stim[rec][F_CV]);
			cdb_tag[0] = PREG_BITS'(stim[rec][F_TAG0]);
			cdb_tag[1] = PREG_BITS'(stim[rec][F_TAG1]);
			flush      = stim[rec][F_FL] != 0;
			if (stim[rec][F_BV] != 0) begin
				assert (stim[rec][F_BSER] < serial)
				else report_problem("branch names an instruction not yet dispatched");
				if (stim[rec][F_BSER] < serial) begin
					br_valid  = 1'b1;
					br_idx    = IDX_BITS'(idx_of[stim[rec][F_BSER]]); // Index returned at dispatch
					br_taken  = stim[rec][F_BT] != 0;
					br_target = stim[rec][F_BTGT];
				end
			end
			mode = stim[rec][F_RR];
			if (mode == 2) begin
				rng       = next_random(rng);
				ret_ready = rng[0];
			end else begin
				ret_ready = mode != 0;
			end
		end else begin
			cdb_valid = '0; // Drain with commit always ready
			flush     = 1'b0;
			ret_ready = 1'b1;
		end
	endtask

	task automatic check_cycle();
		int       rc;
		int       dc;
		int       r;
		bit       run;
		int       free_ret;
		int       exp_free;
		exp_ret_t e;
		rc = 0;
		dc = 0;
		for (int k = 0; k < occ; k++) begin
			r = (head + k) % ROB_DEPTH;
			if (tag_on_cdb(row_tag[r]))
				row_done[r] = 1'b1; // Completed by this cycle's broadcast
		end
		// Retirement takes the done prefix from the head
		run = !flush;
		for (int j = 0; j < SS_WIDTH; j++) begin
			r   = (head + j) % ROB_DEPTH;
			run = run && (j < occ) && row_done[r];
			compare_value($sformatf("ret_valid[%0d]", j), ret_valid[j], run);
			if (run && ret_ready) begin
				rc++;
				if (exp_q.size() == 0) begin
					report_problem("retirement beyond the expected sequence");
				end else begin
					e = exp_q.pop_front();
					compare_value($sformatf("ret_t_new[%0d]", j), ret_t_new[j], e.t_new);
					compare_value($sformatf("ret_t_old[%0d]", j), ret_t_old[j], e.t_old);
					compare_value($sformatf("ret_arch_dest[%0d]", j), ret_arch_dest[j],
						e.arch_dest);
					compare_value($sformatf("ret_op[%0d]", j), ret_op[j], e.op);
					compare_value($sformatf("ret_taken[%0d]", j), ret_taken[j], e.taken);
					compare_value($sformatf("ret_target[%0d]", j), ret_target[j], e.target);
				end
			end
		end
		// Slot i needs i+1 rows free after this cycle's retirements
		free_ret = ROB_DEPTH - occ + rc;
		for (int i = 0; i < SS_WIDTH; i++)
			compare_value($sformatf("disp_ready[%0d]", i), disp_ready[i],
				!flush && (free_ret > i));
		fired = 2'b00;
		for (int i = 0; i < SS_WIDTH; i++) begin
			if (cur_valid[i] && disp_ready[i]) begin
				r = (tail + dc) % ROB_DEPTH;
				compare_value($sformatf("disp_idx[%0d]", i), disp_idx[i], r);
				row_tag[r]  = cur_f[i][0];
				row_done[r] = tag_on_cdb(cur_f[i][0]);
				if (serial < MAX_REC)
					idx_of[serial] = disp_idx[i];
				serial++;
				dc++;
				fired[i] = 1'b1;
			end
		end
		exp_free = flush ? ROB_DEPTH : free_ret - dc;
		compare_value("free_count", free_count, exp_free);
		if (flush) begin
			occ  = 0;
			tail = head; // Refill restarts at the head row
		end else begin
			head = (head + rc) % ROB_DEPTH;
			tail = (tail + dc) % ROB_DEPTH;
			occ  = occ + dc - rc;
		end
	endtask

	// Accepted slots leave the bundle, the rest shift down and stay held
	task automatic advance_bundle();
		if (fired[0]) begin
			if (fired[1]) begin
				cur_valid = 2'b00;
			end else begin
				cur_valid[0] = cur_valid[1];
				cur_valid[1] = 1'b0;
				cur_f[0]     = cur_f[1];
			end
		end
		if (cur_valid == 2'b00 && rec < nrec) begin
			rec++;
			load_bundle(rec);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		flush      = 1'b0;
		disp_valid = '0;
		t_new      = '0;
		t_old      = '0;
		arch_dest  = '0;
		op[0]      = OP_ALU;
		op[1]      = OP_ALU;
		npc        = '0;
		cdb_valid  = '0;
		cdb_tag    = '0;
		br_valid   = 1'b0;
		br_idx     = '0;
		br_taken   = 1'b0;
		br_target  = '0;
		ret_ready  = 1'b0;
		rng        = 32'h7927;
		checks     = 0;
		value_errs = 0;
		other_errs = 0;
		nrec       = 0;
		serial     = 0;
		occ        = 0;
		head       = 0;
		tail       = 0;
		rec        = 0;
		cycles     = 0;
		timed_out  = 1'b0;
		cur_valid  = 2'b00;
		cur_f      = '{default: 0};
		load_golden();
		limit = nrec + 4 * ROB_DEPTH;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;
		load_bundle(0);
		while ((rec < nrec || exp_q.size() != 0) && !timed_out) begin
			drive_inputs();
			@(negedge clock); // Inputs settled since 1 ns after the edge
			check_cycle();
			@(posedge clock);
			#1;
			advance_bundle();
			cycles++;
			if (cycles >= limit && (rec < nrec || exp_q.size() != 0))
				timed_out = 1'b1;
		end
		if (timed_out) begin
			$display("Timeout after %0d cycles, %0d records left, %0d retirements missing",
				cycles, nrec - rec, exp_q.size());
			other_errs++;
		end
		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: rob_top.sv
`timescale 1ns/1ps

module rob_top #(
	parameter int SS_WIDTH  = rob_pkg::SS_WIDTH_DEF,
	parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
	parameter int PREG_BITS = rob_pkg::PREG_BITS_DEF
) (
	input  logic                                         clock,
	input  logic                                         rst_n,
	input  logic                                         flush,

	input  logic [SS_WIDTH-1:0]                          disp_valid,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           t_new,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           t_old,
	input  logic [SS_WIDTH-1:0][rob_pkg::ARCH_BITS-1:0]  arch_dest,
	input  rob_pkg::op_class_e [SS_WIDTH-1:0]            op,
	input  logic [SS_WIDTH-1:0][31:0]                    npc,
	output logic [SS_WIDTH-1:0]                          disp_ready,
	output logic [SS_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0]   disp_idx,

	input  logic [SS_WIDTH-1:0]                          cdb_valid,
	input  logic [SS_WIDTH-1:0][PREG_BITS-1:0]           cdb_tag,

	input  logic                                         br_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0]                 br_idx,
	input  logic                                         br_taken,
	input  logic [31:0]                                  br_target,

	input  logic                                         ret_ready,
	output logic [SS_WIDTH-1:0]                          ret_valid,
	output logic [SS_WIDTH-1:0][PREG_BITS-1:0]           ret_t_new,
	output logic [SS_WIDTH-1:0][PREG_BITS-1:0]           ret_t_old,
	output logic [SS_WIDTH-1:0][rob_pkg::ARCH_BITS-1:0]  ret_arch_dest,
	output rob_pkg::op_class_e [SS_WIDTH-1:0]            ret_op,
	output logic [SS_WIDTH-1:0]                          ret_taken,
	output logic [SS_WIDTH-1:0][31:0]                    ret_target,

	output logic [$clog2(ROB_DEPTH+1)-1:0]               free_count
);

	rob #(
		.SS_WIDTH  (SS_WIDTH),
		.ROB_DEPTH (ROB_DEPTH),
		.PREG_BITS (PREG_BITS)
	) rob_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.disp_valid    (disp_valid),
		.t_new         (t_new),
		.t_old         (t_old),
		.arch_dest     (arch_dest),
		.op            (op),
		.npc           (npc),
		.disp_ready    (disp_ready),
		.disp_idx      (disp_idx),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.br_valid      (br_valid),
		.br_idx        (br_idx),
		.br_taken      (br_taken),
		.br_target     (br_target),
		.ret_ready     (ret_ready),
		.ret_valid     (ret_valid),
		.ret_t_new     (ret_t_new),
		.ret_t_old     (ret_t_old),
		.ret_arch_dest (ret_arch_dest),
		.ret_op        (ret_op),
		.ret_taken     (ret_taken),
		.ret_target    (ret_target),
		.free_count    (free_count)
	);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module rob_tb -f project.f -o rob_sim \
	> build.log 2>&1 && ./obj_dir/rob_sim > sim.log 2>&1 || {
	echo "Build or simulation did not complete, see build.log and sim.log"
	exit 1
}
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: tag_cam.sv
`timescale 1ns/1ps

module tag_cam #(
	parameter int DEPTH    = 8,
	parameter int LANES    = 2,
	parameter int TAG_BITS = 6
) (
	input  logic [LANES-1:0]               lane_valid,
	input  logic [LANES-1:0][TAG_BITS-1:0] lane_tag,
	input  logic [DEPTH-1:0][TAG_BITS-1:0] entry_tag,
	output logic [DEPTH-1:0]               hit
);

	// Per-lane match matrix, one row per stored tag
	logic [DEPTH-1:0][LANES-1:0] match;

	always_comb begin
		for (int e = 0; e < DEPTH; e++) begin
			for (int k = 0; k < LANES; k++) begin
				match[e][k] = lane_valid[k] && (lane_tag[k] == entry_tag[e]);
			end
		end
	end

	// Any lane hitting the entry wakes it up
	always_comb begin
		for (int e = 0; e < DEPTH; e++) begin
			hit[e] = |match[e];
		end
	end

endmodule
